/* beeb_glue_top.f */
logic/beeb_glue_pkg.sv
logic/rom_bank_map.sv
logic/beeb_memory.sv
logic/mouse_axis_emu.sv
logic/joystick_port_mux.sv
logic/beeb_glue_top.sv
tests/beeb_glue_tb.sv

/* logic/beeb_glue_pkg.sv */
`default_nettype none

package beeb_glue_pkg;

	// ====================================================================
	// data types
	// ====================================================================

	// memory bus byte, also the raw analog stick value
	typedef logic [7:0] byte_t;

	// mouse position and clamped step, two's complement
	typedef logic signed [8:0] axis_t;

	// value handed to the core's analog inputs
	typedef logic [11:0] adc_t;

	// ====================================================================
	// sideways rom layout
	// ====================================================================

	// slot bits between ram select and bank offset
	parameter int SLOT_SEL_W = 4;
	// physical bank number width
	parameter int ROM_BANK_W = 4;
	// banks actually present in the rom image
	parameter int NUM_ROM_BANKS = 14;

	// ====================================================================
	// mouse packet and joystick
	// ====================================================================

	// per-packet step limit
	parameter int MOUSE_STEP_LIMIT = 10;
	// position range, same as a signed byte
	parameter int AXIS_MIN = -128;
	parameter int AXIS_MAX = 127;

	// packet layout
	parameter int MOUSE_PKT_W = 25;
	parameter int MOUSE_STB_BIT = 24;
	parameter int MOUSE_X_SIGN_BIT = 4;
	parameter int MOUSE_Y_SIGN_BIT = 5;
	// delta bytes, x at 15..8, y at 23..16
	parameter int MOUSE_X_LSB = 8;
	parameter int MOUSE_Y_LSB = 16;

	// fire button within the 16-bit joystick word
	parameter int FIRE_BIT = 4;

endpackage

`default_nettype wire

/* logic/beeb_glue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module beeb_glue_top #(
	parameter int BANK_OFFSET_W = 14
) (
	input  wire                                               clk_sys,
	input  wire                                               rst,
	input  wire                                               model_sel,
	input  wire                                               rom_load_wr,
	input  wire [beeb_glue_pkg::ROM_BANK_W+BANK_OFFSET_W-1:0] rom_load_addr,
	input  wire beeb_glue_pkg::byte_t                         rom_load_data,
	input  wire [BANK_OFFSET_W+beeb_glue_pkg::SLOT_SEL_W:0]   mem_addr,
	input  wire                                               mem_we_n,
	input  wire beeb_glue_pkg::byte_t                         mem_din,
	output beeb_glue_pkg::byte_t                              mem_dout,
	input  wire [beeb_glue_pkg::MOUSE_PKT_W-1:0]              mouse_packet,
	input  wire                                               mouse_disable,
	input  wire                                               swap_joy,
	input  wire [15:0]                                        joy1_buttons,
	input  wire [15:0]                                        joy2_buttons,
	input  wire beeb_glue_pkg::byte_t                         joy1_x,
	input  wire beeb_glue_pkg::byte_t                         joy1_y,
	input  wire beeb_glue_pkg::byte_t                         joy2_x,
	input  wire beeb_glue_pkg::byte_t                         joy2_y,
	output beeb_glue_pkg::adc_t                               joy1_adc_x,
	output beeb_glue_pkg::adc_t                               joy1_adc_y,
	output beeb_glue_pkg::adc_t                               joy2_adc_x,
	output beeb_glue_pkg::adc_t                               joy2_adc_y,
	output logic                                              joy1_fire_n,
	output logic                                              joy2_fire_n
);

	import beeb_glue_pkg::*;

	logic  m128;
	byte_t port_a_x;
	byte_t port_a_y;
	logic  port_a_fire;

	// ====================================================================
	// model register
	// ====================================================================

	// follows the selector only while reset is held, 0 is model b
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			m128 <= model_sel;
		end
	end

	beeb_memory #(
		.BANK_OFFSET_W (BANK_OFFSET_W)
	) u_beeb_memory (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.m128          (m128),
		.rom_load_wr   (rom_load_wr),
		.rom_load_addr (rom_load_addr),
		.rom_load_data (rom_load_data),
		.mem_addr      (mem_addr),
		.mem_we_n      (mem_we_n),
		.mem_din       (mem_din),
		.mem_dout      (mem_dout)
	);

	// mouse may stand in for stick 1 on port a
	mouse_axis_emu u_mouse_axis_emu (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.mouse_packet  (mouse_packet),
		.mouse_disable (mouse_disable),
		.joy1_buttons  (joy1_buttons),
		.joy1_x        (joy1_x),
		.joy1_y        (joy1_y),
		.port_a_x      (port_a_x),
		.port_a_y      (port_a_y),
		.port_a_fire   (port_a_fire)
	);

	joystick_port_mux u_joystick_port_mux (
		.port_a_x     (port_a_x),
		.port_a_y     (port_a_y),
		.port_a_fire  (port_a_fire),
		.joy2_buttons (joy2_buttons),
		.joy2_x       (joy2_x),
		.joy2_y       (joy2_y),
		.swap_joy     (swap_joy),
		.joy1_adc_x   (joy1_adc_x),
		.joy1_adc_y   (joy1_adc_y),
		.joy2_adc_x   (joy2_adc_x),
		.joy2_adc_y   (joy2_adc_y),
		.joy1_fire_n  (joy1_fire_n),
		.joy2_fire_n  (joy2_fire_n)
	);

endmodule

`default_nettype wire

/* logic/beeb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module beeb_memory #(
	parameter int BANK_OFFSET_W = 14
) (
	input  wire                                                   clk_sys,
	input  wire                                                   rst,
	input  wire                                                   m128,
	input  wire                                                   rom_load_wr,
	input  wire [beeb_glue_pkg::ROM_BANK_W+BANK_OFFSET_W-1:0]     rom_load_addr,
	input  wire beeb_glue_pkg::byte_t                             rom_load_data,
	input  wire [BANK_OFFSET_W+beeb_glue_pkg::SLOT_SEL_W:0]       mem_addr,
	input  wire                                                   mem_we_n,
	input  wire beeb_glue_pkg::byte_t                             mem_din,
	output beeb_glue_pkg::byte_t                                  mem_dout
);

	import beeb_glue_pkg::*;

	localparam int MEM_AW    = BANK_OFFSET_W + SLOT_SEL_W + 1;
	localparam int RAM_AW    = MEM_AW - 1;
	localparam int ROM_AW    = ROM_BANK_W + BANK_OFFSET_W;
	localparam int ROM_DEPTH = NUM_ROM_BANKS * (2 ** BANK_OFFSET_W);

	byte_t rom [ROM_DEPTH];
	byte_t ram [2 ** RAM_AW];

	logic                     ram_sel;
	logic [SLOT_SEL_W-1:0]    slot;
	logic [BANK_OFFSET_W-1:0] offset;
	logic [ROM_BANK_W-1:0]    bank;
	logic                     bank_hit;
	logic [ROM_AW-1:0]        rom_rd_addr;
	logic                     we_n_q;
	logic                     ram_wr;
	byte_t                    rom_q;
	byte_t                    ram_q;
	logic                     ram_sel_q;
	logic                     hit_q;

	// ====================================================================
	// address split
	// ====================================================================

	// top bit ram, then slot, then offset within the bank
	assign ram_sel = mem_addr[MEM_AW-1];
	assign slot    = mem_addr[RAM_AW-1:BANK_OFFSET_W];
	assign offset  = mem_addr[BANK_OFFSET_W-1:0];

	rom_bank_map #(
		.BANK_OFFSET_W (BANK_OFFSET_W)
	) u_rom_bank_map (
		.m128     (m128),
		.slot_sel (slot),
		.bank     (bank),
		.bank_hit (bank_hit)
	);

	assign rom_rd_addr = {bank, offset};

	// ====================================================================
	// rom image
	// ====================================================================

	// image is only written while the core is held in reset
	always_ff @(posedge clk_sys) begin
		if (rst && rom_load_wr && (rom_load_addr < ROM_DEPTH)) begin
			rom[rom_load_addr] <= rom_load_data;
		end
		rom_q <= rom[rom_rd_addr];
	end

	// ====================================================================
	// sideways and shadow ram
	// ====================================================================

	// write once on the high to low step of the strobe
	assign ram_wr = ram_sel & we_n_q & ~mem_we_n;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			we_n_q <= 1'b1;
		end else begin
			we_n_q <= mem_we_n;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ram_wr) begin
			ram[mem_addr[RAM_AW-1:0]] <= mem_din;
		end
		ram_q <= ram[mem_addr[RAM_AW-1:0]];
	end

	// ====================================================================
	// read data
	// ====================================================================

	// selects follow the data through the same register stage
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ram_sel_q <= 1'b0;
			hit_q     <= 1'b0;
		end else begin
			ram_sel_q <= ram_sel;
			hit_q     <= bank_hit;
		end
	end

	// unmapped rom slots read as zero
	always_comb begin
		if (ram_sel_q) begin
			mem_dout = ram_q;
		end else if (hit_q) begin
			mem_dout = rom_q;
		end else begin
			mem_dout = '0;
		end
	end

endmodule

`default_nettype wire

/* logic/joystick_port_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module joystick_port_mux (
	input  wire beeb_glue_pkg::byte_t port_a_x,
	input  wire beeb_glue_pkg::byte_t port_a_y,
	input  wire                       port_a_fire,
	input  wire [15:0]                joy2_buttons,
	input  wire beeb_glue_pkg::byte_t joy2_x,
	input  wire beeb_glue_pkg::byte_t joy2_y,
	input  wire                       swap_joy,
	output beeb_glue_pkg::adc_t       joy1_adc_x,
	output beeb_glue_pkg::adc_t       joy1_adc_y,
	output beeb_glue_pkg::adc_t       joy2_adc_x,
	output beeb_glue_pkg::adc_t       joy2_adc_y,
	output logic                      joy1_fire_n,
	output logic                      joy2_fire_n
);

	import beeb_glue_pkg::*;

	// signed stick byte to the core's inverted adc scale
	// low nibble repeats the top nibble to fill 12 bits
	function automatic adc_t axis_to_adc(input byte_t b);
		byte_t inv;
		inv = 8'hFF - {~b[7], b[6:0]};
		return {inv, inv[7:4]};
	endfunction

	adc_t a_adc_x;
	adc_t a_adc_y;
	adc_t b_adc_x;
	adc_t b_adc_y;

	assign a_adc_x = axis_to_adc(port_a_x);
	assign a_adc_y = axis_to_adc(port_a_y);
	assign b_adc_x = axis_to_adc(joy2_x);
	assign b_adc_y = axis_to_adc(joy2_y);

	// swap clear, a on stick 1 and b on stick 2
	assign joy1_adc_x = swap_joy ? b_adc_x : a_adc_x;
	assign joy1_adc_y = swap_joy ? b_adc_y : a_adc_y;
	assign joy2_adc_x = swap_joy ? a_adc_x : b_adc_x;
	assign joy2_adc_y = swap_joy ? a_adc_y : b_adc_y;

	// core fire inputs are active low
	assign joy1_fire_n = swap_joy ? ~joy2_buttons[FIRE_BIT] : ~port_a_fire;
	assign joy2_fire_n = swap_joy ? ~port_a_fire : ~joy2_buttons[FIRE_BIT];

endmodule

`default_nettype wire

/* logic/mouse_axis_emu.sv */
`timescale 1ns/1ps
`default_nettype none

module mouse_axis_emu (
	input  wire                                  clk_sys,
	input  wire                                  rst,
	input  wire [beeb_glue_pkg::MOUSE_PKT_W-1:0] mouse_packet,
	input  wire                                  mouse_disable,
	input  wire [15:0]                           joy1_buttons,
	input  wire beeb_glue_pkg::byte_t            joy1_x,
	input  wire beeb_glue_pkg::byte_t            joy1_y,
	output beeb_glue_pkg::byte_t                 port_a_x,
	output beeb_glue_pkg::byte_t                 port_a_y,
	output logic                                 port_a_fire
);

	import beeb_glue_pkg::*;

	// saturate to lo..hi, result always fits the axis type
	function automatic axis_t clamp_axis(input int v, input int lo, input int hi);
		int r;
		r = v;
		if (v < lo) begin
			r = lo;
		end else if (v > hi) begin
			r = hi;
		end
		return axis_t'(r);
	endfunction

	axis_t dx_raw;
	axis_t dy_raw;
	axis_t dx;
	axis_t dy;
	axis_t pos_x;
	axis_t pos_y;
	axis_t next_x;
	axis_t next_y;
	logic  stb_q;
	logic  pkt_new;
	logic  mouse_clr;
	logic  active;

	// ====================================================================
	// packet decode
	// ====================================================================

	// sign bit in the header byte, magnitude byte further up
	assign dx_raw = {mouse_packet[MOUSE_X_SIGN_BIT], mouse_packet[MOUSE_X_LSB +: 8]};
	assign dy_raw = {mouse_packet[MOUSE_Y_SIGN_BIT], mouse_packet[MOUSE_Y_LSB +: 8]};

	// limit one step
	assign dx = clamp_axis(int'(dx_raw), -MOUSE_STEP_LIMIT, MOUSE_STEP_LIMIT);
	assign dy = clamp_axis(int'(dy_raw), -MOUSE_STEP_LIMIT, MOUSE_STEP_LIMIT);

	// mouse y grows upward, stick y grows downward
	assign next_x = clamp_axis(int'(pos_x) + int'(dx), AXIS_MIN, AXIS_MAX);
	assign next_y = clamp_axis(int'(pos_y) - int'(dy), AXIS_MIN, AXIS_MAX);

	// toggle strobe marks a fresh packet
	assign pkt_new   = mouse_packet[MOUSE_STB_BIT] != stb_q;
	// any stick button hands port a back to the stick
	assign mouse_clr = rst | mouse_disable | (|joy1_buttons);

	// ====================================================================
	// position state
	// ====================================================================

	always_ff @(posedge clk_sys) begin
		stb_q <= mouse_packet[MOUSE_STB_BIT];
		if (mouse_clr) begin
			active <= 1'b0;
			pos_x  <= '0;
			pos_y  <= '0;
		end else if (pkt_new) begin
			active <= 1'b1;
			pos_x  <= next_x;
			pos_y  <= next_y;
		end
	end

	// port a source, mouse buttons 0 and 1 both act as fire
	assign port_a_x    = active ? byte_t'(pos_x[7:0]) : joy1_x;
	assign port_a_y    = active ? byte_t'(pos_y[7:0]) : joy1_y;
	assign port_a_fire = active ? (|mouse_packet[1:0]) : joy1_buttons[FIRE_BIT];

endmodule

`default_nettype wire

/* logic/rom_bank_map.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_bank_map #(
	parameter int BANK_OFFSET_W = 14
) (
	input  wire                                 m128,
	input  wire [beeb_glue_pkg::SLOT_SEL_W-1:0] slot_sel,
	output logic [beeb_glue_pkg::ROM_BANK_W-1:0] bank,
	output logic                                bank_hit
);

	import beeb_glue_pkg::*;

	logic [ROM_BANK_W-1:0] table_bank;
	logic                  table_hit;

	// model b slots hold os, filing system, ram utility and basic
	// master slots hold adfs, mmfs, mos, dfs, viewsheet, edit, basic4, adfs, view, terminal
	always_comb begin
		table_bank = '0;
		table_hit  = 1'b0;
		if (!m128) begin
			case (slot_sel)
				4:  begin table_bank = 0;  table_hit = 1'b1; end
				8:  begin table_bank = 1;  table_hit = 1'b1; end
				14: begin table_bank = 2;  table_hit = 1'b1; end
				15: begin table_bank = 3;  table_hit = 1'b1; end
				default: ;
			endcase
		end else begin
			case (slot_sel)
				2:  begin table_bank = 4;  table_hit = 1'b1; end
				3:  begin table_bank = 5;  table_hit = 1'b1; end
				4:  begin table_bank = 6;  table_hit = 1'b1; end
				9:  begin table_bank = 7;  table_hit = 1'b1; end
				10: begin table_bank = 8;  table_hit = 1'b1; end
				11: begin table_bank = 9;  table_hit = 1'b1; end
				12: begin table_bank = 10; table_hit = 1'b1; end
				13: begin table_bank = 11; table_hit = 1'b1; end
				14: begin table_bank = 12; table_hit = 1'b1; end
				15: begin table_bank = 13; table_hit = 1'b1; end
				default: ;
			endcase
		end
	end

	// bank 0 on a miss keeps the rom read index in range
	assign bank = table_bank;

	assign bank_hit = table_hit;

endmodule

`default_nettype wire

/* tests/beeb_glue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module beeb_glue_tb;

	import beeb_glue_pkg::*;

	localparam int OFF_W      = 4;
	localparam int BANK_BYTES = 2 ** OFF_W;
	localparam int ROM_DEPTH  = NUM_ROM_BANKS * BANK_BYTES;
	localparam int MAX_REC    = 64;
	localparam int MAX_FLD    = 14;

	logic                        clk_sys;
	logic                        rst;
	logic                        model_sel;
	logic                        rom_load_wr;
	logic [ROM_BANK_W+OFF_W-1:0] rom_load_addr;
	byte_t                       rom_load_data;
	logic [OFF_W+SLOT_SEL_W:0]   mem_addr;
	logic                        mem_we_n;
	byte_t                       mem_din;
	byte_t                       mem_dout;
	logic [MOUSE_PKT_W-1:0]      mouse_packet;
	logic                        mouse_disable;
	logic                        swap_joy;
	logic [15:0]                 joy1_buttons;
	logic [15:0]                 joy2_buttons;
	byte_t                       joy1_x;
	byte_t                       joy1_y;
	byte_t                       joy2_x;
	byte_t                       joy2_y;
	adc_t                        joy1_adc_x;
	adc_t                        joy1_adc_y;
	adc_t                        joy2_adc_x;
	adc_t                        joy2_adc_y;
	logic                        joy1_fire_n;
	logic                        joy2_fire_n;

	// reference copies of what went into the dut
	byte_t      rom_model [ROM_DEPTH];
	byte_t      ram_model [256];
	logic [7:0] written [$];

	// parsed vector records
	logic [7:0]  ops [MAX_REC];
	logic [63:0] fld [MAX_REC][MAX_FLD];
	int          num_rec;
	int          budget_cycles;
	int          seed;
	// current level of the mouse toggle strobe
	logic        stb;

	always #50 clk_sys = ~clk_sys;

	beeb_glue_top #(
		.BANK_OFFSET_W (OFF_W)
	) u_beeb_glue_top (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.model_sel     (model_sel),
		.rom_load_wr   (rom_load_wr),
		.rom_load_addr (rom_load_addr),
		.rom_load_data (rom_load_data),
		.mem_addr      (mem_addr),
		.mem_we_n      (mem_we_n),
		.mem_din       (mem_din),
		.mem_dout      (mem_dout),
		.mouse_packet  (mouse_packet),
		.mouse_disable (mouse_disable),
		.swap_joy      (swap_joy),
		.joy1_buttons  (joy1_buttons),
		.joy2_buttons  (joy2_buttons),
		.joy1_x        (joy1_x),
		.joy1_y        (joy1_y),
		.joy2_x        (joy2_x),
		.joy2_y        (joy2_y),
		.joy1_adc_x    (joy1_adc_x),
		.joy1_adc_y    (joy1_adc_y),
		.joy2_adc_x    (joy2_adc_x),
		.joy2_adc_y    (joy2_adc_y),
		.joy1_fire_n   (joy1_fire_n),
		.joy2_fire_n   (joy2_fire_n)
	);

	// ====================================================================
	// helpers
	// ====================================================================

	// inputs change and outputs are sampled 5 ns after the edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic fail_run();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("ERROR %0t ns: %s read 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			fail_run();
		end
	endtask

	// fields that follow each operation letter
	function automatic int field_count(input logic [7:0] op);
		case (op)
			"L": return 0;
			"M": return 1;
			"R": return 1;
			"X": return 2;
			"W": return 1;
			"H": return 2;
			"P": return 7;
			"J": return 14;
			default: return -1;
		endcase
	endfunction

	// rough cycle cost of one record on top of a fixed margin
	function automatic int record_cycles(input logic [7:0] op, input logic [63:0] f0,
		input logic [63:0] f1);
		case (op)
			"L": return ROM_DEPTH;
			"R": return 16 * BANK_BYTES;
			"W": return 4 * f0;
			"H": return 5 * f1;
			"P": return f0;
			default: return 0;
		endcase
	endfunction

	// bank 14 and up is unmapped and reads zero
	function automatic byte_t expected_rom(input logic [3:0] bank, input logic [3:0] off);
		if (bank < NUM_ROM_BANKS) begin
			return rom_model[bank * BANK_BYTES + off];
		end
		return 8'h00;
	endfunction

	// ====================================================================
	// memory operations
	// ====================================================================

	// upper nibble tags the bank and lower nibble is random per byte
	task automatic load_rom();
		int a;
		rst = 1'b1;
		rom_load_wr = 1'b1;
		for (a = 0; a < ROM_DEPTH; a++) begin
			rom_model[a]  = {4'(a / BANK_BYTES + 1), 4'(a % BANK_BYTES) ^ 4'($urandom)};
			rom_load_addr = a;
			rom_load_data = rom_model[a];
			next_cycle();
		end
		rom_load_wr = 1'b0;
	endtask

	task automatic reset_with_model(input logic m);
		rst       = 1'b1;
		model_sel = m;
		repeat (3) next_cycle();
		rst = 1'b0;
	endtask

	// one map digit per slot with slot 0 leftmost
	task automatic read_all_slots(input logic [63:0] map);
		int s;
		int o;
		logic [3:0] bank;
		byte_t prev;
		logic have_prev;
		have_prev = 1'b0;
		prev      = '0;
		for (s = 0; s < 16; s++) begin
			bank = map[(15 - s) * 4 +: 4];
			for (o = 0; o < BANK_BYTES; o++) begin
				mem_addr = (s << OFF_W) | o;
				// old byte stays until the next edge
				#1;
				if (have_prev) begin
					check_value("rom data before the edge", mem_dout, prev);
				end
				next_cycle();
				prev = expected_rom(bank, o);
				check_value($sformatf("rom slot %0d offset %0d", s, o), mem_dout, prev);
				have_prev = 1'b1;
			end
		end
	endtask

	// one low pulse and the strobe high again before the next
	task automatic ram_store(input logic [7:0] idx, input byte_t d);
		mem_addr = {1'b1, idx};
		mem_din  = d;
		mem_we_n = 1'b0;
		next_cycle();
		mem_we_n = 1'b1;
		next_cycle();
		ram_model[idx] = d;
	endtask

	task automatic ram_read(input logic [7:0] idx);
		mem_addr = {1'b1, idx};
		next_cycle();
		check_value($sformatf("ram index 0x%0h", idx), mem_dout, ram_model[idx]);
	endtask

	task automatic fill_random_ram(input int n);
		int k;
		logic [7:0] idx;
		written.delete();
		for (k = 0; k < n; k++) begin
			idx = $urandom;
			ram_store(idx, $urandom);
			written.push_back(idx);
		end
		for (k = 0; k < written.size(); k++) begin
			ram_read(written[k]);
		end
	endtask

	// strobe held low across several addresses writes only the first
	task automatic hold_we_low(input logic [7:0] start, input int cycles);
		int k;
		logic [7:0] idx;
		byte_t first;
		for (k = 0; k < cycles; k++) begin
			ram_store(start + k, $urandom);
		end
		first    = ~ram_model[start];
		mem_we_n = 1'b0;
		for (k = 0; k < cycles; k++) begin
			idx      = start + k;
			mem_addr = {1'b1, idx};
			mem_din  = (k == 0) ? first : ~ram_model[idx];
			next_cycle();
		end
		mem_we_n = 1'b1;
		next_cycle();
		ram_model[start] = first;
		for (k = 0; k < cycles; k++) begin
			ram_read(start + k);
		end
	endtask

	// write pulse at a rom address leaves the contents alone
	task automatic poke_rom_addr(input logic [8:0] addr, input logic [3:0] bank);
		mem_addr = {1'b0, addr[7:0]};
		mem_din  = $urandom;
		mem_we_n = 1'b0;
		next_cycle();
		mem_we_n = 1'b1;
		next_cycle();
		next_cycle();
		check_value("rom after write pulse", mem_dout, expected_rom(bank, addr[3:0]));
	endtask

	// ====================================================================
	// mouse and joystick operations
	// ====================================================================

	// count, toggle, x sign, x byte, y sign, y byte, buttons
	task automatic send_packets(input int r);
		int k;
		logic [MOUSE_PKT_W-1:0] pkt;
		for (k = 0; k < fld[r][0]; k++) begin
			if (fld[r][1][0]) begin
				stb = ~stb;
			end
			pkt                    = '0;
			pkt[MOUSE_STB_BIT]     = stb;
			pkt[MOUSE_X_SIGN_BIT]  = fld[r][2][0];
			pkt[MOUSE_X_LSB +: 8]  = fld[r][3][7:0];
			pkt[MOUSE_Y_SIGN_BIT]  = fld[r][4][0];
			pkt[MOUSE_Y_LSB +: 8]  = fld[r][5][7:0];
			pkt[1:0]               = fld[r][6][1:0];
			mouse_packet           = pkt;
			next_cycle();
		end
	endtask

	// inputs settle over one edge before all six outputs are compared
	task automatic drive_and_check_sticks(input int r);
		joy1_buttons  = fld[r][0][15:0];
		joy1_x        = fld[r][1][7:0];
		joy1_y        = fld[r][2][7:0];
		joy2_buttons  = fld[r][3][15:0];
		joy2_x        = fld[r][4][7:0];
		joy2_y        = fld[r][5][7:0];
		mouse_disable = fld[r][6][0];
		swap_joy      = fld[r][7][0];
		next_cycle();
		check_value("joy1 adc x", joy1_adc_x, fld[r][8]);
		check_value("joy1 adc y", joy1_adc_y, fld[r][9]);
		check_value("joy2 adc x", joy2_adc_x, fld[r][10]);
		check_value("joy2 adc y", joy2_adc_y, fld[r][11]);
		check_value("joy1 fire_n", joy1_fire_n, fld[r][12]);
		check_value("joy2 fire_n", joy2_fire_n, fld[r][13]);
	endtask

	// ====================================================================
	// main sequence
	// ====================================================================

	initial begin
		int fd;
		int code;
		int nf;
		int k;
		int r;
		int total;
		logic [7:0] op;
		logic [63:0] v;
		logic [8*256-1:0] line_buf;
		logic done;
		clk_sys       = 1'b0;
		rst           = 1'b1;
		model_sel     = 1'b0;
		rom_load_wr   = 1'b0;
		rom_load_addr = '0;
		rom_load_data = '0;
		mem_addr      = '0;
		mem_we_n      = 1'b1;
		mem_din       = '0;
		mouse_packet  = '0;
		mouse_disable = 1'b0;
		swap_joy      = 1'b0;
		joy1_buttons  = '0;
		joy2_buttons  = '0;
		joy1_x        = '0;
		joy1_y        = '0;
		joy2_x        = '0;
		joy2_y        = '0;
		stb           = 1'b0;
		num_rec       = 0;
		total         = 3;
		seed          = 32'h5e21d0b3;
		v             = $urandom(seed);

		fd = $fopen("tests/beeb_glue_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/beeb_glue_vectors.txt");
			fail_run();
		end
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", op);
			if (code != 1) begin
				done = 1'b1;
			end else if (op == "#") begin
				code = $fgets(line_buf, fd);
			end else begin
				nf = field_count(op);
				if (nf < 0 || num_rec >= MAX_REC) begin
					$display("vector file has an unknown or surplus record %c", op);
					fail_run();
				end
				ops[num_rec] = op;
				for (k = 0; k < nf; k++) begin
					code = $fscanf(fd, "%h", v);
					if (code != 1) begin
						$display("vector record %0d is missing a field", num_rec);
						fail_run();
					end
					fld[num_rec][k] = v;
				end
				total += 20 + record_cycles(op, fld[num_rec][0], fld[num_rec][1]);
				num_rec++;
			end
		end
		$fclose(fd);
		// watchdog starts once the full length is known
		budget_cycles = total;

		// reset stays high into the load and model records
		repeat (3) next_cycle();
		for (r = 0; r < num_rec; r++) begin
			case (ops[r])
				"L": load_rom();
				"M": reset_with_model(fld[r][0][0]);
				"R": read_all_slots(fld[r][0]);
				"X": poke_rom_addr(fld[r][0][8:0], fld[r][1][3:0]);
				"W": fill_random_ram(fld[r][0]);
				"H": hold_we_low(fld[r][0][7:0], fld[r][1]);
				"P": send_packets(r);
				"J": drive_and_check_sticks(r);
				default: ;
			endcase
		end

		$display("Result: PASSED");
		$finish;
	end

	initial begin
		wait (budget_cycles > 0);
		repeat (budget_cycles) @(posedge clk_sys);
		$display("timeout: records did not finish within %0d cycles", budget_cycles);
		fail_run();
	end

endmodule

`default_nettype wire

/* tests/beeb_glue_vectors.txt */
# all fields hex. L | M model | R bank per slot, slot 0 first, f none | X addr bank | W count
# H ram index count | P count toggle xs dx ys dy btn | J j1b j1x j1y j2b j2x j2y dis swap e1x e1y e2x e2y f1n f2n
L
M 0
R ffff0fff1fffff23
X 0e3 2
X 053 f
M 1
R ff456ffff789abcd
X 0a7 8
X 043 6
W 14
H 3c 4
J 0000 14 f6 0000 05 fb 0 0 6b6 898 7a7 848 1 1
P 1 1 0 64 0 05 0
J 0000 14 f6 0000 05 fb 0 0 757 848 7a7 848 1 1
P 1 1 1 9c 1 9c 1
J 0000 14 f6 0000 05 fb 0 0 7f7 7a7 7a7 848 0 1
P 1 0 0 7f 0 7f 1
J 0000 14 f6 0000 05 fb 0 0 7f7 7a7 7a7 848 0 1
P e 1 0 64 1 9c 0
J 0000 14 f6 0000 05 fb 0 0 000 000 7a7 848 1 1
P 1e 1 1 9c 0 64 0
J 0000 14 f6 0000 05 fb 0 0 fff fff 7a7 848 1 1
J 0010 14 f6 0000 05 fb 0 0 6b6 898 7a7 848 0 1
J 0000 14 f6 0000 05 fb 0 0 6b6 898 7a7 848 1 1
P 1 1 0 05 0 05 0
J 0000 14 f6 0000 05 fb 0 0 7a7 848 7a7 848 1 1
J 0000 14 f6 0000 05 fb 1 0 6b6 898 7a7 848 1 1
P 1 1 0 05 0 05 1
J 0000 14 f6 0000 05 fb 0 0 6b6 898 7a7 848 1 1
J 0000 14 f6 0010 05 fb 0 1 7a7 848 6b6 898 0 1
